// ==== design/excp_pkg.sv ====
package excp_pkg;

    localparam int cause_w = 16;
    localparam int vppn_w = 19;

    // cause vector bit positions, lower bit has priority
    localparam int cause_int = 0;
    localparam int cause_adef = 1;
    localparam int cause_tlbr_fetch = 2;
    localparam int cause_pif = 3;
    localparam int cause_ppi_fetch = 4;
    localparam int cause_sys = 5;
    localparam int cause_brk = 6;
    localparam int cause_ine = 7;
    localparam int cause_ipe = 8;
    localparam int cause_ale = 9;
    localparam int cause_adem = 10;
    localparam int cause_tlbr_mem = 11;
    localparam int cause_pme = 12;
    localparam int cause_ppi_mem = 13;
    localparam int cause_pis = 14;
    localparam int cause_pil = 15;

    localparam logic [5:0] ecode_int = 6'h00;
    localparam logic [5:0] ecode_pil = 6'h01;
    localparam logic [5:0] ecode_pis = 6'h02;
    localparam logic [5:0] ecode_pif = 6'h03;
    localparam logic [5:0] ecode_pme = 6'h04;
    localparam logic [5:0] ecode_ppi = 6'h07;
    localparam logic [5:0] ecode_ade = 6'h08;
    localparam logic [5:0] ecode_ale = 6'h09;
    localparam logic [5:0] ecode_sys = 6'h0b;
    localparam logic [5:0] ecode_brk = 6'h0c;
    localparam logic [5:0] ecode_ine = 6'h0d;
    localparam logic [5:0] ecode_ipe = 6'h0e;
    localparam logic [5:0] ecode_tlbr = 6'h3f;

    // ADE is split by subcode, everything else uses zero
    localparam logic [8:0] esub_adef = 9'd0;
    localparam logic [8:0] esub_adem = 9'd1;

    localparam logic [31:0] excp_entry = 32'h1c00_8000;

    typedef struct packed {
        logic [5:0]        ecode;
        logic [8:0]        esubcode;
        logic              va_valid;
        logic [31:0]       bad_va;
        logic              tlb_refill;
        logic              tlb_excp;
        logic [vppn_w-1:0] vppn;
    } excp_report_t;

endpackage

// ==== design/core_pkg.sv ====
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count = 2 ** reg_addr_w;
    localparam int lane_count = 2;
    // ex, mem1, mem2
    localparam int stall_src_count = 3;

    // what an instruction does at commit
    typedef enum logic [2:0] {
        op_alu,
        op_ll,
        op_sc,
        op_ertn,
        op_idle
    } op_class_t;

    // one writeback lane entering commit
    typedef struct packed {
        logic                         valid;
        logic [xlen-1:0]              pc;
        op_class_t                    op;
        logic                         is_pri;
        logic                         wb_en;
        logic [reg_addr_w-1:0]        wb_dest;
        logic [xlen-1:0]              wb_data;
        logic [xlen-1:0]              mem_addr;
        logic [excp_pkg::cause_w-1:0] cause;
    } commit_lane_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } reg_write_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
        logic            from_excp;
        logic            from_ertn;
        logic            from_idle;
    } flush_t;

    // debug word map, words below reg_count are the GPRs
    localparam int dbg_addr_w = 6;
    localparam logic [dbg_addr_w-1:0] dbg_era = 6'd32;
    localparam logic [dbg_addr_w-1:0] dbg_estat = 6'd33;
    localparam logic [dbg_addr_w-1:0] dbg_badv = 6'd34;
    localparam logic [dbg_addr_w-1:0] dbg_tlb_page = 6'd35;
    localparam logic [dbg_addr_w-1:0] dbg_llbit = 6'd36;

endpackage

// ==== design/commit_ctrl.sv ====
`timescale 1ns/1ps

module commit_ctrl (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  core_pkg::commit_lane_t [core_pkg::lane_count-1:0]     lane_i,
    input  logic [core_pkg::stall_src_count-1:0]                  stall_req_i,
    input  logic                                                  issue_pri_i,
    input  logic [core_pkg::xlen-1:0]                             era_i,
    output logic [excp_pkg::cause_w-1:0]                          cause_o,
    output logic                                                  excp_take_o,
    output logic [core_pkg::xlen-1:0]                             excp_pc_o,
    output logic [core_pkg::xlen-1:0]                             excp_addr_o,
    output logic                                                  excp_idle_o,
    output logic                                                  ertn_take_o,
    output logic                                                  llbit_we_o,
    output logic                                                  llbit_val_o,
    output core_pkg::reg_write_t [core_pkg::lane_count-1:0]       reg_wr_o,
    output core_pkg::flush_t                                      flush_o,
    output logic                                                  stall_o,
    output logic                                                  pri_stall_o
);

    logic has_cause0;
    logic has_cause1;
    logic excp0;
    logic excp1;
    logic kill1;
    logic [core_pkg::lane_count-1:0] retire;
    logic ertn0;
    logic idle0;

    assign has_cause0 = |lane_i[0].cause;
    assign has_cause1 = |lane_i[1].cause;

    // lane 1 is younger, it dies behind a faulting or serializing lane 0
    assign kill1 = lane_i[0].valid && (has_cause0 || lane_i[0].op == core_pkg::op_ertn
                                       || lane_i[0].op == core_pkg::op_idle);

    assign retire[0] = lane_i[0].valid && !has_cause0;
    assign retire[1] = lane_i[1].valid && !has_cause1 && !kill1;

    assign excp0 = lane_i[0].valid && has_cause0;
    assign excp1 = lane_i[1].valid && has_cause1 && !kill1;
    assign excp_take_o = excp0 || excp1;

    // oldest faulting lane feeds the encoder and the CSRs
    always_comb begin
        cause_o = '0;
        excp_pc_o = '0;
        excp_addr_o = '0;
        if (excp0) begin
            cause_o = lane_i[0].cause;
            excp_pc_o = lane_i[0].pc;
            excp_addr_o = lane_i[0].mem_addr;
        end else if (excp1) begin
            cause_o = lane_i[1].cause;
            excp_pc_o = lane_i[1].pc;
            excp_addr_o = lane_i[1].mem_addr;
        end
    end

    // idle woken by an interrupt resumes after itself
    assign excp_idle_o = excp0 && lane_i[0].op == core_pkg::op_idle;

    assign ertn0 = retire[0] && lane_i[0].op == core_pkg::op_ertn;
    assign idle0 = retire[0] && lane_i[0].op == core_pkg::op_idle;
    assign ertn_take_o = ertn0;

    assign llbit_we_o = retire[0] && !excp_take_o
                        && (lane_i[0].op == core_pkg::op_ll || lane_i[0].op == core_pkg::op_sc);
    assign llbit_val_o = lane_i[0].op == core_pkg::op_ll;

    always_comb begin
        for (int i = 0; i < core_pkg::lane_count; i++) begin
            reg_wr_o[i].en = retire[i] && lane_i[i].wb_en;
            reg_wr_o[i].addr = lane_i[i].wb_dest;
            reg_wr_o[i].data = lane_i[i].wb_data;
        end
    end

    // at most one flush source per cycle
    always_comb begin
        flush_o = '0;
        flush_o.valid = excp_take_o || ertn0 || idle0;
        flush_o.from_excp = excp_take_o;
        flush_o.from_ertn = ertn0;
        flush_o.from_idle = idle0;
        if (excp_take_o) begin
            flush_o.target = excp_pkg::excp_entry;
        end else if (ertn0) begin
            flush_o.target = era_i;
        end else if (idle0) begin
            flush_o.target = lane_i[0].pc + core_pkg::xlen'(4);
        end
    end

    assign stall_o = |stall_req_i;

    // hold issue while a privileged op is in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            pri_stall_o <= 1'b0;
        end else if (issue_pri_i) begin
            pri_stall_o <= 1'b1;
        end else if ((retire[0] && lane_i[0].is_pri) || excp_take_o) begin
            pri_stall_o <= 1'b0;
        end
    end

    a_no_young_write: assert property (@(posedge clk) disable iff (rst)
        (flush_o.from_excp && excp0) |-> !reg_wr_o[1].en);

    a_pri_stall_reset: assert property (@(posedge clk) $fell(rst) |-> !pri_stall_o);

endmodule

// ==== design/excp_encoder.sv ====
`timescale 1ns/1ps

module excp_encoder (
    input  logic [excp_pkg::cause_w-1:0] cause_i,
    input  logic [core_pkg::xlen-1:0]    pc_i,
    input  logic [core_pkg::xlen-1:0]    mem_addr_i,
    output excp_pkg::excp_report_t       report_o
);

    localparam int idx_w = $clog2(excp_pkg::cause_w);

    logic [idx_w-1:0] idx;
    logic             hit;
    logic             fetch_va;
    logic             mem_va;

    // lowest set bit wins
    always_comb begin
        hit = 1'b0;
        idx = '0;
        for (int i = excp_pkg::cause_w - 1; i >= 0; i--) begin
            if (cause_i[i]) begin
                hit = 1'b1;
                idx = idx_w'(i);
            end
        end
    end

    assign fetch_va = hit && (idx inside {excp_pkg::cause_adef, excp_pkg::cause_tlbr_fetch,
                                          excp_pkg::cause_pif, excp_pkg::cause_ppi_fetch});
    // all causes from ale upward carry the data address
    assign mem_va = hit && idx >= excp_pkg::cause_ale;

    always_comb begin
        report_o = '0;
        if (hit) begin
            case (idx)
                excp_pkg::cause_int:        report_o.ecode = excp_pkg::ecode_int;
                excp_pkg::cause_adef:       report_o.ecode = excp_pkg::ecode_ade;
                excp_pkg::cause_tlbr_fetch: report_o.ecode = excp_pkg::ecode_tlbr;
                excp_pkg::cause_pif:        report_o.ecode = excp_pkg::ecode_pif;
                excp_pkg::cause_ppi_fetch:  report_o.ecode = excp_pkg::ecode_ppi;
                excp_pkg::cause_sys:        report_o.ecode = excp_pkg::ecode_sys;
                excp_pkg::cause_brk:        report_o.ecode = excp_pkg::ecode_brk;
                excp_pkg::cause_ine:        report_o.ecode = excp_pkg::ecode_ine;
                excp_pkg::cause_ipe:        report_o.ecode = excp_pkg::ecode_ipe;
                excp_pkg::cause_ale:        report_o.ecode = excp_pkg::ecode_ale;
                excp_pkg::cause_adem:       report_o.ecode = excp_pkg::ecode_ade;
                excp_pkg::cause_tlbr_mem:   report_o.ecode = excp_pkg::ecode_tlbr;
                excp_pkg::cause_pme:        report_o.ecode = excp_pkg::ecode_pme;
                excp_pkg::cause_ppi_mem:    report_o.ecode = excp_pkg::ecode_ppi;
                excp_pkg::cause_pis:        report_o.ecode = excp_pkg::ecode_pis;
                default:                    report_o.ecode = excp_pkg::ecode_pil;
            endcase
            report_o.esubcode = (idx == excp_pkg::cause_adem) ? excp_pkg::esub_adem
                                                                : excp_pkg::esub_adef;
        end
        report_o.va_valid = fetch_va || mem_va;
        report_o.bad_va = fetch_va ? pc_i : (mem_va ? mem_addr_i : '0);
        report_o.tlb_refill = hit && (idx inside {excp_pkg::cause_tlbr_fetch,
                                                  excp_pkg::cause_tlbr_mem});
        report_o.tlb_excp = report_o.tlb_refill
            || (hit && (idx inside {excp_pkg::cause_pif, excp_pkg::cause_ppi_fetch,
                                    excp_pkg::cause_pme, excp_pkg::cause_ppi_mem,
                                    excp_pkg::cause_pis, excp_pkg::cause_pil}));
        if (report_o.tlb_excp) begin
            report_o.vppn = report_o.bad_va[core_pkg::xlen-1 -: excp_pkg::vppn_w];
        end
    end

endmodule

// ==== design/arch_regfile.sv ====
`timescale 1ns/1ps

module arch_regfile (
    input  logic                                            clk,
    input  logic                                            rst,
    input  core_pkg::reg_write_t [core_pkg::lane_count-1:0] wr_i,
    input  logic [core_pkg::reg_addr_w-1:0]                 rd_addr_i,
    output logic [core_pkg::xlen-1:0]                       rd_data_o
);

    logic [core_pkg::xlen-1:0] regs [core_pkg::reg_count];

    // later port is the younger lane, so it lands last and wins
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < core_pkg::reg_count; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < core_pkg::lane_count; p++) begin
                if (wr_i[p].en && wr_i[p].addr != '0) begin
                    regs[wr_i[p].addr] <= wr_i[p].data;
                end
            end
        end
    end

    // r0 is hardwired
    assign rd_data_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

// ==== design/excp_csr.sv ====
`timescale 1ns/1ps

module excp_csr (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            excp_take_i,
    input  logic [core_pkg::xlen-1:0]       excp_pc_i,
    input  logic                            idle_i,
    input  excp_pkg::excp_report_t          report_i,
    input  logic                            ertn_take_i,
    input  logic                            llbit_we_i,
    input  logic                            llbit_val_i,
    input  logic [core_pkg::dbg_addr_w-1:0] rd_addr_i,
    output logic [core_pkg::xlen-1:0]       rd_data_o,
    output logic [core_pkg::xlen-1:0]       era_o
);

    logic [core_pkg::xlen-1:0] era;
    logic [core_pkg::xlen-1:0] estat;
    logic [core_pkg::xlen-1:0] badv;
    logic [core_pkg::xlen-1:0] tlb_page;
    logic                      llbit;

    always_ff @(posedge clk) begin
        if (rst) begin
            era <= '0;
            estat <= '0;
            badv <= '0;
            tlb_page <= '0;
            llbit <= 1'b0;
        end else begin
            if (excp_take_i) begin
                era <= idle_i ? excp_pc_i + core_pkg::xlen'(4) : excp_pc_i;
                // esubcode 30:22, ecode 21:16
                estat <= {1'b0, report_i.esubcode, report_i.ecode, 16'h0000};
                // page number sits in the upper bits like TLBEHI
                tlb_page <= {report_i.vppn, {(core_pkg::xlen - excp_pkg::vppn_w){1'b0}}};
                if (report_i.va_valid) begin
                    badv <= report_i.bad_va;
                end
            end
            if (ertn_take_i) begin
                llbit <= 1'b0;
            end else if (llbit_we_i) begin
                llbit <= llbit_val_i;
            end
        end
    end

    assign era_o = era;

    always_comb begin
        case (rd_addr_i)
            core_pkg::dbg_era:      rd_data_o = era;
            core_pkg::dbg_estat:    rd_data_o = estat;
            core_pkg::dbg_badv:     rd_data_o = badv;
            core_pkg::dbg_tlb_page: rd_data_o = tlb_page;
            core_pkg::dbg_llbit:    rd_data_o = {{(core_pkg::xlen - 1){1'b0}}, llbit};
            default:                rd_data_o = '0;
        endcase
    end

    a_excp_ertn_excl: assert property (@(posedge clk) disable iff (rst)
        !(excp_take_i && ertn_take_i));

endmodule

// ==== design/debug_wb_port.sv ====
`timescale 1ns/1ps

module debug_wb_port (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            dbg_cyc_i,
    input  logic                            dbg_stb_i,
    input  logic                            dbg_we_i,
    input  logic [core_pkg::dbg_addr_w-1:0] dbg_adr_i,
    output logic                            dbg_ack_o,
    output logic [core_pkg::xlen-1:0]       dbg_dat_o,
    output logic [core_pkg::dbg_addr_w-1:0] rd_addr_o,
    input  logic [core_pkg::xlen-1:0]       rf_data_i,
    input  logic [core_pkg::xlen-1:0]       csr_data_i
);

    logic                            req;
    logic                            is_read;
    logic [core_pkg::dbg_addr_w-1:0] adr_q;

    // new request only when no ack is out, gives a gap between acks
    assign req = dbg_cyc_i && dbg_stb_i && !dbg_ack_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            dbg_ack_o <= 1'b0;
            is_read <= 1'b0;
        end else begin
            dbg_ack_o <= req;
            if (req) begin
                is_read <= !dbg_we_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            adr_q <= dbg_adr_i;
        end
    end

    assign rd_addr_o = adr_q;

    // writes return zero and touch nothing
    always_comb begin
        dbg_dat_o = '0;
        if (is_read) begin
            dbg_dat_o = (adr_q < core_pkg::reg_count) ? rf_data_i : csr_data_i;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst) dbg_ack_o |=> !dbg_ack_o);

endmodule

// ==== design/commit_top.sv ====
`timescale 1ns/1ps

module commit_top (
    input  logic                                              clk,
    input  logic                                              rst,
    input  core_pkg::commit_lane_t [core_pkg::lane_count-1:0] lane_i,
    input  logic [core_pkg::stall_src_count-1:0]              stall_req_i,
    input  logic                                              issue_pri_i,
    input  logic                                              dbg_cyc_i,
    input  logic                                              dbg_stb_i,
    input  logic                                              dbg_we_i,
    input  logic [core_pkg::dbg_addr_w-1:0]                   dbg_adr_i,
    output logic                                              dbg_ack_o,
    output logic [core_pkg::xlen-1:0]                         dbg_dat_o,
    output core_pkg::flush_t                                  flush_o,
    output logic                                              stall_o,
    output logic                                              pri_stall_o
);

    logic [excp_pkg::cause_w-1:0]                    cause;
    logic                                            excp_take;
    logic [core_pkg::xlen-1:0]                       excp_pc;
    logic [core_pkg::xlen-1:0]                       excp_addr;
    logic                                            excp_idle;
    logic                                            ertn_take;
    logic                                            llbit_we;
    logic                                            llbit_val;
    logic [core_pkg::xlen-1:0]                       era;
    excp_pkg::excp_report_t                          report;
    core_pkg::reg_write_t [core_pkg::lane_count-1:0] reg_wr;
    logic [core_pkg::dbg_addr_w-1:0]                 dbg_rd_addr;
    logic [core_pkg::xlen-1:0]                       rf_data;
    logic [core_pkg::xlen-1:0]                       csr_data;

    commit_ctrl i_commit_ctrl (
        .clk(clk), .rst(rst), .lane_i(lane_i), .stall_req_i(stall_req_i),
        .issue_pri_i(issue_pri_i), .era_i(era), .cause_o(cause), .excp_take_o(excp_take),
        .excp_pc_o(excp_pc), .excp_addr_o(excp_addr), .excp_idle_o(excp_idle),
        .ertn_take_o(ertn_take), .llbit_we_o(llbit_we), .llbit_val_o(llbit_val),
        .reg_wr_o(reg_wr), .flush_o(flush_o), .stall_o(stall_o), .pri_stall_o(pri_stall_o)
    );

    excp_encoder i_excp_encoder (
        .cause_i(cause), .pc_i(excp_pc), .mem_addr_i(excp_addr), .report_o(report)
    );

    arch_regfile i_arch_regfile (
        .clk(clk), .rst(rst), .wr_i(reg_wr),
        .rd_addr_i(dbg_rd_addr[core_pkg::reg_addr_w-1:0]), .rd_data_o(rf_data)
    );

    excp_csr i_excp_csr (
        .clk(clk), .rst(rst), .excp_take_i(excp_take), .excp_pc_i(excp_pc),
        .idle_i(excp_idle), .report_i(report), .ertn_take_i(ertn_take),
        .llbit_we_i(llbit_we), .llbit_val_i(llbit_val), .rd_addr_i(dbg_rd_addr),
        .rd_data_o(csr_data), .era_o(era)
    );

    debug_wb_port i_debug_wb_port (
        .clk(clk), .rst(rst), .dbg_cyc_i(dbg_cyc_i), .dbg_stb_i(dbg_stb_i),
        .dbg_we_i(dbg_we_i), .dbg_adr_i(dbg_adr_i), .dbg_ack_o(dbg_ack_o),
        .dbg_dat_o(dbg_dat_o), .rd_addr_o(dbg_rd_addr), .rf_data_i(rf_data),
        .csr_data_i(csr_data)
    );

endmodule

// ==== testbench/tb_commit.sv ====
`timescale 1ns/1ps

module tb_commit;

    localparam int clk_period = 20;
    localparam int reset_cycles = 16;
    localparam int burst_count = 24;
    localparam int burst_len = 40;
    localparam int dbg_words = 37;
    localparam int dbg_writes = 4;
    // one debug access takes about four cycles
    localparam int test_cycles = reset_cycles
        + burst_count * (burst_len + 4 * (dbg_words + dbg_writes));
    localparam int timeout_cycles = test_cycles * 4 + 1000;

    logic                                              clk;
    logic                                              rst;
    core_pkg::commit_lane_t [core_pkg::lane_count-1:0] lane;
    logic [core_pkg::stall_src_count-1:0]              stall_req;
    logic                                              issue_pri;
    logic                                              dbg_cyc;
    logic                                              dbg_stb;
    logic                                              dbg_we;
    logic [core_pkg::dbg_addr_w-1:0]                   dbg_adr;
    logic                                              dbg_ack;
    logic [core_pkg::xlen-1:0]                         dbg_dat;
    core_pkg::flush_t                                  flush;
    logic                                              stall;
    logic                                              pri_stall;

    // reference state
    logic [core_pkg::xlen-1:0] m_regs [core_pkg::reg_count];
    logic [core_pkg::xlen-1:0] m_era;
    logic [core_pkg::xlen-1:0] m_estat;
    logic [core_pkg::xlen-1:0] m_badv;
    logic [core_pkg::xlen-1:0] m_tlb_page;
    logic                      m_llbit;
    logic                      m_pri_stall;

    commit_top i_commit_top (
        .clk(clk), .rst(rst), .lane_i(lane), .stall_req_i(stall_req),
        .issue_pri_i(issue_pri), .dbg_cyc_i(dbg_cyc), .dbg_stb_i(dbg_stb),
        .dbg_we_i(dbg_we), .dbg_adr_i(dbg_adr), .dbg_ack_o(dbg_ack), .dbg_dat_o(dbg_dat),
        .flush_o(flush), .stall_o(stall), .pri_stall_o(pri_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        abort_run();
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_word(input string name, input logic [core_pkg::xlen-1:0] exp,
                              input logic [core_pkg::xlen-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flush(input string name, input core_pkg::flush_t exp,
                               input core_pkg::flush_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // ecode per cause bit
    function automatic logic [5:0] expected_ecode(input int idx);
        case (idx)
            0:       return 6'h00;
            1, 10:   return 6'h08;
            2, 11:   return 6'h3f;
            3:       return 6'h03;
            4, 13:   return 6'h07;
            5:       return 6'h0b;
            6:       return 6'h0c;
            7:       return 6'h0d;
            8:       return 6'h0e;
            9:       return 6'h09;
            12:      return 6'h04;
            14:      return 6'h02;
            default: return 6'h01;
        endcase
    endfunction

    task automatic random_lane(output core_pkg::commit_lane_t l);
        logic [31:0] rnd;
        int          r;
        l = '0;
        rnd = $urandom();
        l.valid = $urandom_range(99) < 85;
        l.pc = $urandom() & 32'hffff_fffc;
        r = $urandom_range(99);
        if (r < 4) l.op = core_pkg::op_ll;
        else if (r < 8) l.op = core_pkg::op_sc;
        else if (r < 11) l.op = core_pkg::op_ertn;
        else if (r < 15) l.op = core_pkg::op_idle;
        else l.op = core_pkg::op_alu;
        l.is_pri = $urandom_range(9) == 0;
        l.wb_en = $urandom_range(4) != 0;
        l.wb_dest = rnd[core_pkg::reg_addr_w-1:0];
        l.wb_data = $urandom();
        l.mem_addr = $urandom();
        if ($urandom_range(9) == 0) begin
            l.cause[$urandom_range(excp_pkg::cause_w - 1)] = 1'b1;
            // occasionally a second cause bit
            if ($urandom_range(1) == 1) l.cause[$urandom_range(excp_pkg::cause_w - 1)] = 1'b1;
        end
    endtask

    // one commit cycle through the model and the flush it predicts
    task automatic model_step(input core_pkg::commit_lane_t [core_pkg::lane_count-1:0] l,
                              input logic pri_req, output core_pkg::flush_t exp_flush);
        logic                      has0;
        logic                      has1;
        logic                      kill1;
        logic                      ret0;
        logic                      ret1;
        logic                      ex0;
        logic                      excp;
        logic                      ertn0;
        logic                      idle0;
        logic                      fetch_va;
        logic                      mem_va;
        logic                      tlb_excp;
        logic [core_pkg::xlen-1:0] bad_va;
        logic [8:0]                esub;
        core_pkg::commit_lane_t    el;
        int                        idx;
        has0 = |l[0].cause;
        has1 = |l[1].cause;
        kill1 = l[0].valid && (has0 || l[0].op == core_pkg::op_ertn
                               || l[0].op == core_pkg::op_idle);
        ret0 = l[0].valid && !has0;
        ret1 = l[1].valid && !has1 && !kill1;
        ex0 = l[0].valid && has0;
        excp = ex0 || (l[1].valid && has1 && !kill1);
        ertn0 = ret0 && l[0].op == core_pkg::op_ertn;
        idle0 = ret0 && l[0].op == core_pkg::op_idle;

        exp_flush = '0;
        exp_flush.valid = excp || ertn0 || idle0;
        exp_flush.from_excp = excp;
        exp_flush.from_ertn = ertn0;
        exp_flush.from_idle = idle0;
        if (excp) exp_flush.target = excp_pkg::excp_entry;
        else if (ertn0) exp_flush.target = m_era;
        else if (idle0) exp_flush.target = l[0].pc + 32'd4;

        if (ret0 && l[0].wb_en && l[0].wb_dest != 0) m_regs[l[0].wb_dest] = l[0].wb_data;
        if (ret1 && l[1].wb_en && l[1].wb_dest != 0) m_regs[l[1].wb_dest] = l[1].wb_data;

        if (excp) begin
            el = ex0 ? l[0] : l[1];
            idx = 0;
            for (int i = excp_pkg::cause_w - 1; i >= 0; i--) begin
                if (el.cause[i]) idx = i;
            end
            fetch_va = idx >= 1 && idx <= 4;
            mem_va = idx >= 9;
            tlb_excp = idx inside {2, 3, 4, 11, 12, 13, 14, 15};
            bad_va = fetch_va ? el.pc : (mem_va ? el.mem_addr : 32'd0);
            esub = (idx == 10) ? 9'd1 : 9'd0;
            m_era = (ex0 && el.op == core_pkg::op_idle) ? el.pc + 32'd4 : el.pc;
            m_estat = {1'b0, esub, expected_ecode(idx), 16'h0000};
            if (fetch_va || mem_va) m_badv = bad_va;
            m_tlb_page = tlb_excp ? {bad_va[31:13], 13'd0} : 32'd0;
        end

        if (ertn0) m_llbit = 1'b0;
        else if (ret0 && !excp && l[0].op inside {core_pkg::op_ll, core_pkg::op_sc})
            m_llbit = l[0].op == core_pkg::op_ll;

        if (pri_req) m_pri_stall = 1'b1;
        else if ((ret0 && l[0].is_pri) || excp) m_pri_stall = 1'b0;
    endtask

    task automatic commit_cycle();
        core_pkg::commit_lane_t [core_pkg::lane_count-1:0] next;
        logic [31:0]                                       rnd;
        logic [core_pkg::stall_src_count-1:0]              req;
        logic                                              pri_req;
        core_pkg::flush_t                                  exp_flush;
        logic                                              exp_pri;
        random_lane(next[0]);
        random_lane(next[1]);
        if ($urandom_range(4) == 0) next[1].wb_dest = next[0].wb_dest;
        rnd = $urandom();
        req = ($urandom_range(1) == 0) ? '0 : rnd[core_pkg::stall_src_count-1:0];
        pri_req = $urandom_range(19) == 0;
        @(posedge clk);
        lane <= next;
        stall_req <= req;
        issue_pri <= pri_req;
        @(negedge clk);
        exp_pri = m_pri_stall;
        model_step(next, pri_req, exp_flush);
        check_flush("commit flush", exp_flush, flush);
        check_bit("stall", |req, stall);
        check_bit("privilege stall", exp_pri, pri_stall);
    endtask

    task automatic park_lanes();
        @(posedge clk);
        lane <= '0;
        stall_req <= '0;
        issue_pri <= 1'b0;
    endtask

    task automatic dbg_access(input logic we_in, input logic [core_pkg::dbg_addr_w-1:0] adr_in,
                              output logic [core_pkg::xlen-1:0] data);
        int wait_cycles;
        @(posedge clk);
        dbg_cyc <= 1'b1;
        dbg_stb <= 1'b1;
        dbg_we <= we_in;
        dbg_adr <= adr_in;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 16) begin
                $display("debug port gave no ack within 16 cycles");
                abort_run();
            end
        end while (!dbg_ack);
        check_word("ack latency", 32'd1, core_pkg::xlen'(wait_cycles - 1));
        data = dbg_dat;
        @(posedge clk);
        dbg_cyc <= 1'b0;
        dbg_stb <= 1'b0;
        dbg_we <= 1'b0;
        @(negedge clk);
        check_bit("ack single cycle", 1'b0, dbg_ack);
    endtask

    task automatic write_probe();
        logic [31:0] rnd;
        logic [31:0] data;
        for (int n = 0; n < dbg_writes; n++) begin
            rnd = $urandom_range(dbg_words - 1);
            dbg_access(1'b1, rnd[core_pkg::dbg_addr_w-1:0], data);
        end
    endtask

    task automatic readback_all();
        logic [core_pkg::xlen-1:0] data;
        logic [core_pkg::xlen-1:0] exp;
        for (int a = 0; a < dbg_words; a++) begin
            dbg_access(1'b0, core_pkg::dbg_addr_w'(a), data);
            if (a < core_pkg::reg_count) exp = m_regs[a];
            else if (a == core_pkg::dbg_era) exp = m_era;
            else if (a == core_pkg::dbg_estat) exp = m_estat;
            else if (a == core_pkg::dbg_badv) exp = m_badv;
            else if (a == core_pkg::dbg_tlb_page) exp = m_tlb_page;
            else exp = {31'd0, m_llbit};
            check_word($sformatf("debug word %0d", a), exp, data);
        end
    endtask

    initial begin
        rst = 1'b1;
        lane = '0;
        stall_req = '0;
        issue_pri = 1'b0;
        dbg_cyc = 1'b0;
        dbg_stb = 1'b0;
        dbg_we = 1'b0;
        dbg_adr = '0;
        void'($urandom(32'hbd1032a9));
        for (int r = 0; r < core_pkg::reg_count; r++) m_regs[r] = '0;
        m_era = '0;
        m_estat = '0;
        m_badv = '0;
        m_tlb_page = '0;
        m_llbit = 1'b0;
        m_pri_stall = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("privilege stall after reset", 1'b0, pri_stall);
        check_bit("ack after reset", 1'b0, dbg_ack);
        check_flush("flush after reset", '0, flush);
        readback_all();
        for (int b = 0; b < burst_count; b++) begin
            repeat (burst_len) commit_cycle();
            park_lanes();
            write_probe();
            readback_all();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== files.f ====
design/excp_pkg.sv
design/core_pkg.sv
design/commit_ctrl.sv
design/excp_encoder.sv
design/arch_regfile.sv
design/excp_csr.sv
design/debug_wb_port.sv
design/commit_top.sv
testbench/tb_commit.sv

// ==== Makefile ====
# Verilator flow for the commit stage

VERILATOR ?= verilator
TOP       ?= tb_commit
RTL_TOP   ?= commit_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
LINTFLAGS ?= --lint-only

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits nonzero on $fatal
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
